// File: design/tilemap_pkg.sv
// Shared geometry, register map and bus/stream structs; every RTL block imports it in its header
package tilemap_pkg;

    // Raster geometry in pixels and lines
    localparam int H_TOTAL  = 80;
    localparam int V_TOTAL  = 20;
    localparam int H_ACTIVE = 64;   // Visible pixels per line
    localparam int V_ACTIVE = 16;   // Visible lines per frame

    localparam int X_BITS = 7;      // Enough for H_TOTAL-1
    localparam int Y_BITS = 5;      // Enough for V_TOTAL-1

    // A page is 32x32 tiles of 8x8 pixels, so 256x256 pixels
    localparam int PAGE_TILES = 32;
    localparam int PAGE_WORDS = 1024;
    localparam int RAM_WORDS  = 4096;   // Four pages fill the tilemap RAM

    // Byte offsets inside the char window (address bits 11:9 all ones)
    localparam logic [8:0] REG_S1_PAGES_FLIP = 9'h08e;
    localparam logic [8:0] REG_S1_PAGES_NOFL = 9'h09e;
    localparam logic [8:0] REG_S2_PAGES_FLIP = 9'h08c;
    localparam logic [8:0] REG_S2_PAGES_NOFL = 9'h09c;
    localparam logic [8:0] REG_S1_VPOS       = 9'h124;
    localparam logic [8:0] REG_S2_VPOS       = 9'h126;
    localparam logic [8:0] REG_S1_HPOS       = 9'h1f8;
    localparam logic [8:0] REG_S2_HPOS       = 9'h1fa;

    // One CPU write cycle, word addressed like the 68000 bus
    typedef struct packed {
        logic [12:1] addr;
        logic [15:0] data;
        logic [1:0]  dsn;   // Active low, bit 1 is the upper byte
    } cpu_wr_t;

    // Scroll state of one layer as seen by the address path
    typedef struct packed {
        logic [15:0] hpos;
        logic [15:0] vpos;
        logic [15:0] pages;  // Four nibbles, one per quadrant
    } layer_cfg_t;

    typedef struct packed {
        logic [X_BITS-1:0] x;
        logic [Y_BITS-1:0] y;
        logic              active;
        logic              slot;   // 0 serves layer 1, 1 serves layer 2
    } raster_t;

    typedef struct packed {
        logic              layer;
        logic [X_BITS-1:0] x;
        logic [Y_BITS-1:0] y;
        logic [15:0]       word;
    } tile_out_t;

endpackage

// File: design/scroll_regs.sv
// Scroll and page register window on the CPU bus; feeds the per-layer configuration to the address path
module scroll_regs import tilemap_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flip,
    input  logic       char_cs,
    input  cpu_wr_t    wr,
    output layer_cfg_t cfg1,
    output layer_cfg_t cfg2
);

    logic [15:0] s1_pages_flip, s1_pages_nofl;
    logic [15:0] s2_pages_flip, s2_pages_nofl;
    logic [15:0] s1_hpos, s1_vpos;
    logic [15:0] s2_hpos, s2_vpos;
    logic [15:0] s1_pages, s2_pages;  // Page word picked by flip, one cycle behind
    logic        hit;                 // Write lands inside the register window
    logic [8:0]  offs;                // Byte offset within the window

    // Keep the old byte wherever its strobe is inactive
    function automatic logic [15:0] merge(input logic [15:0] old, input cpu_wr_t w);
        merge = {w.dsn[1] ? old[15:8] : w.data[15:8],
                 w.dsn[0] ? old[7:0]  : w.data[7:0]};
    endfunction

    assign hit  = char_cs && (wr.addr[11:9] == 3'b111) && (wr.dsn != 2'b11);
    assign offs = {wr.addr[8:1], 1'b0};   // Registers sit on even byte offsets

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_pages_flip <= '0;
            s1_pages_nofl <= '0;
            s2_pages_flip <= '0;
            s2_pages_nofl <= '0;
            s1_hpos       <= '0;
            s1_vpos       <= '0;
            s2_hpos       <= '0;
            s2_vpos       <= '0;
        end else if (hit) begin
            case (offs)
                REG_S1_PAGES_FLIP: s1_pages_flip <= merge(s1_pages_flip, wr);
                REG_S1_PAGES_NOFL: s1_pages_nofl <= merge(s1_pages_nofl, wr);
                REG_S2_PAGES_FLIP: s2_pages_flip <= merge(s2_pages_flip, wr);
                REG_S2_PAGES_NOFL: s2_pages_nofl <= merge(s2_pages_nofl, wr);
                REG_S1_VPOS:       s1_vpos       <= merge(s1_vpos, wr);
                REG_S2_VPOS:       s2_vpos       <= merge(s2_vpos, wr);
                REG_S1_HPOS:       s1_hpos       <= merge(s1_hpos, wr);
                REG_S2_HPOS:       s2_hpos       <= merge(s2_hpos, wr);
                default: ;                                   // Other window offsets are ignored
            endcase
        end
    end

    // Flipped screens read the alternate page set
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_pages <= '0;
            s2_pages <= '0;
        end else begin
            s1_pages <= flip ? s1_pages_flip : s1_pages_nofl;
            s2_pages <= flip ? s2_pages_flip : s2_pages_nofl;
        end
    end

    always_comb begin
        cfg1.hpos  = s1_hpos;   // Scroll values go out straight from the registers
        cfg1.vpos  = s1_vpos;
        cfg1.pages = s1_pages;
        cfg2.hpos  = s2_hpos;
        cfg2.vpos  = s2_vpos;
        cfg2.pages = s2_pages;
    end

endmodule

// File: design/tile_ram.sv
// Tilemap storage with a byte-lane CPU write port and a registered video read port
module tile_ram import tilemap_pkg::*; (
    input  logic        clk,
    input  logic        tile_cs,
    input  cpu_wr_t     wr,
    input  logic [11:0] rd_addr,
    output logic [15:0] rd_data
);

    logic [15:0] mem [RAM_WORDS];
    logic        wr_hi;   // Upper byte lane enabled
    logic        wr_lo;   // Lower byte lane enabled
    logic [11:0] wr_addr;

    assign wr_hi   = tile_cs && !wr.dsn[1];
    assign wr_lo   = tile_cs && !wr.dsn[0];
    assign wr_addr = wr.addr;   // The whole 12-bit word address indexes the RAM

    // Each lane is a separate write enable so the two halves stay independent
    always_ff @(posedge clk) begin
        if (wr_hi) begin
            mem[wr_addr][15:8] <= wr.data[15:8];
        end
        if (wr_lo) begin
            mem[wr_addr][7:0] <= wr.data[7:0];
        end
    end

    // Video side sees data one clock after presenting the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: design/raster_counter.sv
// Beam position generator; every pixel spends one clock on each layer before x advances
module raster_counter import tilemap_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    output raster_t pos
);

    logic [X_BITS-1:0] x;
    logic [Y_BITS-1:0] y;
    logic              slot;
    logic              x_end;   // Last pixel of the line
    logic              y_end;   // Last line of the frame

    assign x_end = (x == X_BITS'(H_TOTAL - 1));
    assign y_end = (y == Y_BITS'(V_TOTAL - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot <= 1'b0;
            x    <= '0;
            y    <= '0;
        end else begin
            slot <= ~slot;
            if (slot) begin                          // Move on once layer 2 had its turn
                if (x_end) begin
                    x <= '0;
                    y <= y_end ? '0 : y + 1'b1;
                end else begin
                    x <= x + 1'b1;
                end
            end
        end
    end

    always_comb begin
        pos.x      = x;
        pos.y      = y;
        pos.slot   = slot;
        pos.active = (x < X_BITS'(H_ACTIVE)) && (y < Y_BITS'(V_ACTIVE));
    end

endmodule

// File: design/layer_addr.sv
// Scroll and page translation of one layer: screen position in, tilemap word address out
module layer_addr import tilemap_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  raster_t     pos,
    input  layer_cfg_t  cfg,
    output logic [11:0] addr
);

    logic [8:0]  vx;        // Position in the 512x512 virtual plane
    logic [8:0]  vy;
    logic [1:0]  quad;      // Which 256x256 quarter of the plane
    logic [3:0]  nib;
    logic [1:0]  page;
    logic [11:0] addr_next;

    always_comb begin
        vx   = {2'b00, pos.x} + cfg.hpos[8:0];   // Sums wrap at 512 by width
        vy   = {4'b0000, pos.y} + cfg.vpos[8:0];
        quad = {vy[8], vx[8]};
        nib  = cfg.pages[quad*4 +: 4];               // Quadrant 0 reads the low nibble
        page = nib[1:0];
        // Bit 8 of each coordinate is spent on the quadrant so only bits 7:3 index the page
        addr_next = 12'(int'(page) * PAGE_WORDS
                      + int'(vy[7:3]) * PAGE_TILES
                      + int'(vx[7:3]));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr <= '0;
        end else begin
            addr <= addr_next;   // Ready the clock after the raster sample
        end
    end

endmodule

// File: design/tile_fetch.sv
// Shares the RAM read port between both layers and tags each returned word with its layer and pixel
module tile_fetch import tilemap_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  raster_t     pos,
    input  logic [11:0] addr1,
    input  logic [11:0] addr2,
    input  logic [15:0] rd_data,
    output logic [11:0] rd_addr,
    output logic        tile_valid,
    output tile_out_t   tile
);

    raster_t s1;   // Sample whose address is being read this cycle
    raster_t s2;   // Sample whose RAM data is arriving this cycle

    // The layer addresses lag the raster by one clock, so s1 says whose turn it is
    assign rd_addr = s1.slot ? addr2 : addr1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1         <= '0;
            s2         <= '0;
            tile_valid <= 1'b0;
        end else begin
            s1         <= pos;
            s2         <= s1;
            tile_valid <= s2.active;   // Three clocks after the raster sample
        end
    end

    // Payload follows the same timing as tile_valid
    always_ff @(posedge clk) begin
        tile.layer <= s2.slot;
        tile.x     <= s2.x;
        tile.y     <= s2.y;
        tile.word  <= rd_data;
    end

endmodule

// File: design/tilemap_top.sv
// Two-layer scrolling tilemap fetch; CPU writes set up RAM and scroll, the raster drives a tile stream
module tilemap_top import tilemap_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        flip,
    input  logic        tile_cs,
    input  logic        char_cs,
    input  logic [12:1] cpu_addr,   // Word address from the CPU bus
    input  logic [15:0] cpu_dout,
    input  logic [1:0]  dsn,
    output logic        tile_valid,
    output tile_out_t   tile
);

    cpu_wr_t     wr;
    layer_cfg_t  cfg1, cfg2;
    raster_t     pos;
    logic [11:0] addr1, addr2;
    logic [11:0] rd_addr;
    logic [15:0] rd_data;

    // Both write targets see the same bundle and decode their own select
    assign wr = '{addr: cpu_addr, data: cpu_dout, dsn: dsn};

    scroll_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .flip    (flip),
        .char_cs (char_cs),
        .wr      (wr),
        .cfg1    (cfg1),
        .cfg2    (cfg2)
    );

    tile_ram u_ram (
        .clk     (clk),
        .tile_cs (tile_cs),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    raster_counter u_raster (
        .clk (clk),
        .rst (rst),
        .pos (pos)
    );

    layer_addr u_addr1 (.clk(clk), .rst(rst), .pos(pos), .cfg(cfg1), .addr(addr1));  // Layer 1
    layer_addr u_addr2 (.clk(clk), .rst(rst), .pos(pos), .cfg(cfg2), .addr(addr2));  // Layer 2

    tile_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .pos        (pos),
        .addr1      (addr1),
        .addr2      (addr2),
        .rd_data    (rd_data),
        .rd_addr    (rd_addr),
        .tile_valid (tile_valid),
        .tile       (tile)
    );

endmodule

// File: test/tb_props.sv
// Assertions on tile stream timing and reset, bound into every tilemap_top instance
module tb_props import tilemap_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      active,       // Raster active flag inside the DUT
    input logic      tile_valid,
    input tile_out_t tile
);
    timeunit 1ns;
    timeprecision 1ps;

    // The output register is cleared as soon as reset is applied
    valid_low_in_reset: assert property (@(posedge clk) rst |-> !tile_valid)
        else $error("tile_valid is high while reset is asserted");

    // Three pipeline stages sit between the raster and the stream
    valid_needs_active: assert property (@(posedge clk) disable iff (rst)
        !$past(active, 3) |-> !tile_valid)
        else $error("tile_valid is high although the raster was outside the active area");

    layer_alternates: assert property (@(posedge clk) disable iff (rst)
        tile_valid && $past(tile_valid) |-> tile.layer != $past(tile.layer))
        else $error("two consecutive valid tiles carry the same layer");

endmodule

// Raster flag is taken from inside the top level
bind tilemap_top tb_props props0 (
    .clk        (clk),
    .rst        (rst),
    .active     (pos.active),
    .tile_valid (tile_valid),
    .tile       (tile)
);

// File: test/tb_top.sv
// Directed testbench for tilemap_top; models the RAM and scroll registers and checks full frames of tiles
module tb_top import tilemap_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_TILES = H_ACTIVE * V_ACTIVE * 2;   // Both layers per visible pixel
    localparam int FRAME_CLKS  = H_TOTAL * V_TOTAL * 2;

    logic        clk;
    logic        rst;
    logic        flip;
    logic        tile_cs;
    logic        char_cs;
    logic [12:1] cpu_addr;
    logic [15:0] cpu_dout;
    logic [1:0]  dsn;
    logic        tile_valid;
    tile_out_t   tile;

    logic [15:0] model_ram [RAM_WORDS];   // What the tilemap RAM should hold
    logic [15:0] model_regs [256];        // Register window, one word per even byte offset
    logic        model_flip;
    integer      seed;

    tilemap_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .flip       (flip),
        .tile_cs    (tile_cs),
        .char_cs    (char_cs),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .dsn        (dsn),
        .tile_valid (tile_valid),
        .tile       (tile)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // A low strobe bit opens its byte lane
    function automatic logic [15:0] lane_merge(input logic [15:0] old, input logic [15:0] data,
                                               input logic [1:0] strobe);
        logic [15:0] res;
        res = old;
        if (!strobe[1]) res[15:8] = data[15:8];
        if (!strobe[0]) res[7:0] = data[7:0];
        return res;
    endfunction

    // Tile word that should be fetched for one layer at one screen pixel
    function automatic logic [15:0] expected_word(input logic layer, input int x, input int y);
        logic [15:0] hpos;
        logic [15:0] vpos;
        logic [15:0] pages;
        int          vx;
        int          vy;
        int          nibble;
        int          waddr;
        if (!layer) begin
            hpos  = model_regs[REG_S1_HPOS[8:1]];
            vpos  = model_regs[REG_S1_VPOS[8:1]];
            pages = model_flip ? model_regs[REG_S1_PAGES_FLIP[8:1]]
                               : model_regs[REG_S1_PAGES_NOFL[8:1]];
        end else begin
            hpos  = model_regs[REG_S2_HPOS[8:1]];
            vpos  = model_regs[REG_S2_VPOS[8:1]];
            pages = model_flip ? model_regs[REG_S2_PAGES_FLIP[8:1]]
                               : model_regs[REG_S2_PAGES_NOFL[8:1]];
        end
        vx = (x + int'(hpos)) % 512;   // The virtual plane wraps at 512 both ways
        vy = (y + int'(vpos)) % 512;
        nibble = (int'(pages) >> (4 * (2 * (vy / 256) + vx / 256))) % 16;
        // Inside the chosen page only the position within its 256x256 square counts
        waddr = (nibble % 4) * PAGE_WORDS + ((vy % 256) / 8) * PAGE_TILES + (vx % 256) / 8;
        return model_ram[12'(waddr)];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout: %s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    endtask

    // One bus cycle; the DUT takes it on the next edge while the model applies the bus rules now
    task automatic bus_write(input logic to_ram, input logic [12:1] addr, input logic [15:0] data,
                             input logic [1:0] strobe);
        @(posedge clk);
        tile_cs  <= to_ram;
        char_cs  <= !to_ram;
        cpu_addr <= addr;
        cpu_dout <= data;
        dsn      <= strobe;
        if (strobe != 2'b11) begin
            if (to_ram)
                model_ram[addr] = lane_merge(model_ram[addr], data, strobe);
            else if (addr[11:9] == 3'b111)   // Char window only
                model_regs[addr[8:1]] = lane_merge(model_regs[addr[8:1]], data, strobe);
        end
    endtask

    task automatic reg_write(input logic [8:0] offs, input logic [15:0] data,
                             input logic [1:0] strobe);
        bus_write(1'b0, {1'b0, 3'b111, offs[8:1]}, data, strobe);
    endtask

    task automatic release_bus();
        @(posedge clk);
        tile_cs <= 1'b0;
        char_cs <= 1'b0;
        dsn     <= 2'b11;
    endtask

    task automatic set_flip(input logic value);
        @(posedge clk);
        flip       <= value;
        model_flip = value;
    endtask

    // Stops on the first tile of a frame, layer 1 at pixel 0,0
    task automatic wait_frame_start();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 2 * FRAME_CLKS) fail_timeout("no frame start appeared on the tile stream");
        end while (!(tile_valid && tile.x == '0 && tile.y == '0 && tile.layer == 1'b0));
    endtask

    task automatic check_frame();
        int n;
        int idle;
        wait_frame_start();   // This frame may still carry older settings
        wait_frame_start();
        for (n = 0; n < FRAME_TILES; n++) begin
            idle = 0;
            while (!tile_valid) begin
                @(negedge clk);
                idle++;
                if (idle > FRAME_CLKS) fail_timeout("tile stream stopped inside a frame");
            end
            check_value("tile.layer", 32'(tile.layer), 32'(n % 2));
            check_value("tile.x", 32'(tile.x), 32'((n / 2) % H_ACTIVE));
            check_value("tile.y", 32'(tile.y), 32'(n / (2 * H_ACTIVE)));
            check_value("tile.word", 32'(tile.word),
                        32'(expected_word(1'(n % 2), (n / 2) % H_ACTIVE, n / (2 * H_ACTIVE))));
            @(negedge clk);
        end
    endtask

    // Zero scroll and pages: both layers read page 0 straight
    task automatic reset_view();
        for (int i = 0; i < RAM_WORDS; i++) begin
            bus_write(1'b1, 12'(i), 16'($random(seed)), 2'b00);
        end
        release_bus();
        check_frame();
    endtask

    task automatic scroll_wrap();
        reg_write(REG_S1_HPOS, 16'hfdd5, 2'b00);   // x 469..532 wraps past 511
        reg_write(REG_S1_VPOS, 16'h01f8, 2'b00);   // y 504..519 wraps too
        reg_write(REG_S2_HPOS, 16'h0033, 2'b00);
        reg_write(REG_S2_VPOS, 16'h0107, 2'b00);
        release_bus();
        check_frame();
    endtask

    task automatic quadrant_pages();
        reg_write(REG_S1_PAGES_NOFL, 16'he5b4, 2'b00);   // Pages 0,3,1,2 with junk in bits 3:2
        reg_write(REG_S2_PAGES_NOFL, 16'h1032, 2'b00);
        reg_write(REG_S1_HPOS, 16'h00e0, 2'b00);         // Both axes cross 256
        reg_write(REG_S1_VPOS, 16'h00f8, 2'b00);
        reg_write(REG_S2_HPOS, 16'h01e8, 2'b00);         // Crosses 511 back into quadrant 0
        reg_write(REG_S2_VPOS, 16'h00fa, 2'b00);
        release_bus();
        check_frame();
    endtask

    task automatic byte_lane_writes();
        for (int i = 0; i < RAM_WORDS; i++) begin
            bus_write(1'b1, 12'(i), 16'($random(seed)), (i % 2 == 0) ? 2'b01 : 2'b10);
        end
        bus_write(1'b1, 12'h002, 16'hdead, 2'b11);           // No lane open
        reg_write(REG_S2_VPOS, 16'hbeef, 2'b11);
        bus_write(1'b0, {1'b0, 3'b011, REG_S2_HPOS[8:1]}, 16'hffff, 2'b00);   // Outside window
        bus_write(1'b0, {1'b1, 3'b110, REG_S1_PAGES_NOFL[8:1]}, 16'h3333, 2'b00);
        reg_write(REG_S1_HPOS, 16'hab12, 2'b10);             // Lower byte only
        reg_write(REG_S1_VPOS, 16'h01ff, 2'b01);             // Upper byte only
        reg_write(REG_S2_PAGES_NOFL, 16'h21ff, 2'b01);
        release_bus();
        check_frame();
    endtask

    // Flip and no-flip page sets hold different maps
    task automatic flip_page_sets();
        reg_write(REG_S1_PAGES_FLIP, 16'h0123, 2'b00);
        reg_write(REG_S2_PAGES_FLIP, 16'h2301, 2'b00);
        reg_write(REG_S1_HPOS, 16'h00d0, 2'b00);
        release_bus();
        set_flip(1'b1);
        check_frame();
        set_flip(1'b0);
        check_frame();
    endtask

    initial begin
        seed        = 32'hf40795ad;
        rst         = 1'b1;
        flip        = 1'b0;
        tile_cs     = 1'b0;
        char_cs     = 1'b0;
        cpu_addr    = '0;
        cpu_dout    = '0;
        dsn         = 2'b11;
        model_flip  = 1'b0;
        for (int i = 0; i < 256; i++) begin
            model_regs[8'(i)] = '0;   // Registers come out of reset as zero
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        reset_view();
        scroll_wrap();
        quadrant_pages();
        byte_lane_writes();
        flip_page_sets();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: files.f
design/tilemap_pkg.sv
design/scroll_regs.sv
design/tile_ram.sv
design/raster_counter.sv
design/layer_addr.sv
design/tile_fetch.sv
design/tilemap_top.sv
test/tb_props.sv
test/tb_top.sv

// File: run.sh
#!/bin/sh
# Builds the tilemap testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_top -f files.f -o tb_sim
status=0
out=$(./obj_dir/tb_sim 2>&1) || status=$?
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'SIMULATION PASSED'; then
    exit 0
fi
echo "Simulation did not pass (exit status $status)"
exit 1
